/* rtl/videoTimingPkg.sv */
`default_nettype none

// 640 x 480 timing on a 25 MHz pixel clock
package videoTimingPkg;

	// Horizontal, in pixel clock cycles
	localparam int hTotal    = 800;  // Cycles per line
	localparam int hSyncLen  = 96;   // HSYNC low width
	localparam int hActStart = 140;  // First visible cycle
	localparam int hActLen   = 640;  // Visible cycles per line

	// Vertical, in lines
	localparam int vTotal     = 528; // Lines per frame
	localparam int vSyncLines = 2;   // VSYNC low lines
	localparam int vActStart  = 31;  // First visible line
	localparam int vActLen    = 480; // Visible lines per frame

	// Wide enough for either counter
	localparam int countWidth = 11;

	// Scan phase codes
	// Idle doubles as the sync pulse region
	localparam logic [1:0] phIdle  = 2'd0; // Sync low
	localparam logic [1:0] phBack  = 2'd1; // Back porch
	localparam logic [1:0] phDisp  = 2'd2; // Visible
	localparam logic [1:0] phFront = 2'd3; // Front porch

endpackage

`default_nettype wire

/* rtl/frameBufferPkg.sv */
`default_nettype none

// Frame buffer geometry and pixel layout
package frameBufferPkg;

	localparam int fbWidth     = 160;               // Pixels per buffer row
	localparam int fbHeight    = 120;               // Buffer rows
	localparam int fbDepth     = fbWidth * fbHeight; // 19200 words
	localparam int fbAddrWidth = 15;                // Covers fbDepth
	localparam int coordWidth  = 8;                 // Host X and Y

	// Pixel word is three 4-bit channels
	localparam int pixelWidth = 12;
	localparam int chanWidth  = 4;
	localparam int redLsb     = 0;  // Bits 3..0
	localparam int greenLsb   = 4;  // Bits 7..4
	localparam int blueLsb    = 8;  // Bits 11..8

	// DAC channel width on the VGA pins
	localparam int dacWidth = 10;

	// Screen pixel to buffer pixel
	// Each buffer pixel covers 4 x 4 on screen
	localparam int scaleShift = 2;

endpackage

`default_nettype wire

/* rtl/scanIf.sv */
`default_nettype none

// Scan position and syncs from the timing FSM to the pixel path
// No handshake since the scan moves every cycle
interface scanIf
	import videoTimingPkg::*;
();

	logic [countWidth-1:0] hPixel; // Offset from first visible cycle
	logic [countWidth-1:0] vPixel; // Offset from first visible line
	logic                  active; // Inside visible region
	logic                  hSync;  // Active low
	logic                  vSync;  // Active low

	// Timing side
	modport source (
		output hPixel,
		output vPixel,
		output active,
		output hSync,
		output vSync
	);

	// Pixel path side
	modport sink (
		input hPixel,
		input vPixel,
		input active,
		input hSync,
		input vSync
	);

endinterface

`default_nettype wire

/* rtl/scanCounter.sv */
`default_nettype none

// Free running cycle and line counters
module scanCounter
	import videoTimingPkg::*;
(
	input  wire                    CLOCK_25,
	input  wire                    RESET_N,
	output logic [countWidth-1:0]  hCount,  // Cycle within line
	output logic [countWidth-1:0]  vCount,  // Line within frame
	output logic                   lineEnd  // Last cycle of line
);

	logic frameEnd; // Last line of frame

	assign lineEnd  = (hCount == countWidth'(hTotal - 1));
	assign frameEnd = (vCount == countWidth'(vTotal - 1));

	always_ff @(posedge CLOCK_25 or negedge RESET_N) begin
		if (!RESET_N) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			if (lineEnd) begin
				hCount <= '0; // Wrap at 799
				// Line advances together with the wrap
				if (frameEnd) begin
					vCount <= '0; // Wrap at 527
				end else begin
					vCount <= vCount + 1'b1;
				end
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	// Both counters stay inside the frame across every wrap
	countRange: assert property (
		@(posedge CLOCK_25) disable iff (!RESET_N)
		(hCount < countWidth'(hTotal)) && (vCount < countWidth'(vTotal))
	) else $error("scan counter left the frame");

endmodule

`default_nettype wire

/* rtl/scanTimingFsm.sv */
`default_nettype none

// Horizontal and vertical phase FSMs
// Outputs are registered one cycle behind the counters
module scanTimingFsm
	import videoTimingPkg::*;
(
	input  wire                    CLOCK_25,
	input  wire                    RESET_N,
	input  wire [countWidth-1:0]   hCount,
	input  wire [countWidth-1:0]   vCount,
	input  wire                    lineEnd,
	scanIf.source                  scan
);

	logic [1:0] hPhase;      // Phase of previous cycle
	logic [1:0] hPhaseNext;  // Phase of current hCount
	logic [1:0] vPhase;      // Phase of current line
	logic [1:0] vPhaseNext;  // Phase of the coming line

	// Horizontal thresholds compared against the live count
	always_comb begin
		hPhaseNext = hPhase;
		case (hPhase)
			phIdle: begin
				if (hCount >= countWidth'(hSyncLen))
					hPhaseNext = phBack;
			end
			phBack: begin
				if (hCount >= countWidth'(hActStart))
					hPhaseNext = phDisp;
			end
			phDisp: begin
				if (hCount >= countWidth'(hActStart + hActLen))
					hPhaseNext = phFront;
			end
			phFront: begin
				if (hCount < countWidth'(hSyncLen)) // Line wrapped
					hPhaseNext = phIdle;
			end
			default: hPhaseNext = phIdle;
		endcase
	end

	// Vertical thresholds one line early
	// Taken only on lineEnd so vPhase matches the new line
	always_comb begin
		vPhaseNext = vPhase;
		case (vPhase)
			phIdle: begin
				if (vCount >= countWidth'(vSyncLines - 1))
					vPhaseNext = phBack;
			end
			phBack: begin
				if (vCount >= countWidth'(vActStart - 1))
					vPhaseNext = phDisp;
			end
			phDisp: begin
				if (vCount >= countWidth'(vActStart + vActLen - 1))
					vPhaseNext = phFront;
			end
			phFront: begin
				if (vCount == countWidth'(vTotal - 1))
					vPhaseNext = phIdle; // Frame wraps
			end
			default: vPhaseNext = phIdle;
		endcase
	end

	always_ff @(posedge CLOCK_25 or negedge RESET_N) begin
		if (!RESET_N) begin
			hPhase      <= phIdle;
			vPhase      <= phIdle;
			scan.hSync  <= 1'b1;
			scan.vSync  <= 1'b1;
			scan.active <= 1'b0;
		end else begin
			hPhase <= hPhaseNext;
			if (lineEnd)
				vPhase <= vPhaseNext;
			scan.hSync  <= (hCount >= countWidth'(hSyncLen));   // Low for first 96 cycles
			scan.vSync  <= (vCount >= countWidth'(vSyncLines)); // Low for first 2 lines
			scan.active <= (hPhaseNext == phDisp) && (vPhase == phDisp);
		end
	end

	// Screen coordinates, meaningful only while active
	always_ff @(posedge CLOCK_25) begin
		scan.hPixel <= hCount - countWidth'(hActStart);
		scan.vPixel <= vCount - countWidth'(vActStart);
	end

	// Visible region never overlaps either sync pulse
	syncBlank: assert property (
		@(posedge CLOCK_25) disable iff (!RESET_N)
		scan.active |-> (scan.hSync && scan.vSync)
	) else $error("active during sync");

endmodule

`default_nettype wire

/* rtl/frameBuffer.sv */
`default_nettype none

// Pixel memory
// Host write port registered and range checked, scan read port synchronous
module frameBuffer
	import frameBufferPkg::*;
(
	input  wire                     CLOCK_25,
	input  wire                     RESET_N,
	input  wire [coordWidth-1:0]    X,       // Host column
	input  wire [coordWidth-1:0]    Y,       // Host row
	input  wire [pixelWidth-1:0]    RGB,     // Host colour
	input  wire                     WR,      // Write strobe
	input  wire [fbAddrWidth-1:0]   rdAddr,  // Scan read address
	output logic [pixelWidth-1:0]   rdData   // One cycle after rdAddr
);

	logic                   inRange; // Coordinates inside 160 x 120
	logic                   wrEn;
	logic [fbAddrWidth-1:0] wrAddr;
	logic [pixelWidth-1:0]  wrData;

	logic [pixelWidth-1:0]  mem [fbDepth];

	// Out of range writes are dropped, not aliased
	assign inRange = (X < coordWidth'(fbWidth)) && (Y < coordWidth'(fbHeight));

	// Write enable
	always_ff @(posedge CLOCK_25 or negedge RESET_N) begin
		if (!RESET_N) begin
			wrEn <= 1'b0;
		end else begin
			wrEn <= WR && inRange;
		end
	end

	// Address and data captured with the enable
	always_ff @(posedge CLOCK_25) begin
		wrAddr <= fbAddrWidth'(Y * fbWidth + X); // Row major
		wrData <= RGB;
	end

	// Memory array
	always_ff @(posedge CLOCK_25) begin
		if (wrEn)
			mem[wrAddr] <= wrData; // Lands one cycle after WR
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

/* rtl/pixelOutput.sv */
`default_nettype none

// Read address generation and VGA pin stage
// Scan in to pins is three cycles
module pixelOutput
	import videoTimingPkg::*;
	import frameBufferPkg::*;
(
	input  wire                     CLOCK_25,
	input  wire                     RESET_N,
	scanIf.sink                     scan,
	output logic [fbAddrWidth-1:0]  rdAddr,
	input  wire [pixelWidth-1:0]    rdData,
	output logic                    VGA_HSYNC,
	output logic                    VGA_VSYNC,
	output logic                    VGA_BLANK,
	output logic [dacWidth-1:0]     VGA_R,
	output logic [dacWidth-1:0]     VGA_G,
	output logic [dacWidth-1:0]     VGA_B
);

	logic [countWidth-1:0] colIdx;    // Buffer column
	logic [countWidth-1:0] rowIdx;    // Buffer row
	logic [1:0]            activeDly; // [0] with rdAddr, [1] with rdData
	logic [1:0]            hSyncDly;
	logic [1:0]            vSyncDly;

	// Divide screen position by 4
	assign colIdx = scan.hPixel >> scaleShift;
	assign rowIdx = scan.vPixel >> scaleShift;

	always_ff @(posedge CLOCK_25) begin
		rdAddr <= fbAddrWidth'(rowIdx * fbWidth + colIdx);
	end

	// Control follows the memory latency
	always_ff @(posedge CLOCK_25 or negedge RESET_N) begin
		if (!RESET_N) begin
			activeDly <= '0;
			hSyncDly  <= '1; // Syncs idle high
			vSyncDly  <= '1;
		end else begin
			activeDly <= {activeDly[0], scan.active};
			hSyncDly  <= {hSyncDly[0], scan.hSync};
			vSyncDly  <= {vSyncDly[0], scan.vSync};
		end
	end

	// Pin registers
	always_ff @(posedge CLOCK_25 or negedge RESET_N) begin
		if (!RESET_N) begin
			VGA_HSYNC <= 1'b1;
			VGA_VSYNC <= 1'b1;
			VGA_BLANK <= 1'b0;
			VGA_R     <= '0;
			VGA_G     <= '0;
			VGA_B     <= '0;
		end else begin
			VGA_HSYNC <= hSyncDly[1];
			VGA_VSYNC <= vSyncDly[1];
			VGA_BLANK <= activeDly[1]; // High only when visible
			if (activeDly[1]) begin
				// Channel on top, low bits filled with ones
				VGA_R <= {rdData[redLsb +: chanWidth], {(dacWidth - chanWidth){1'b1}}};
				VGA_G <= {rdData[greenLsb +: chanWidth], {(dacWidth - chanWidth){1'b1}}};
				VGA_B <= {rdData[blueLsb +: chanWidth], {(dacWidth - chanWidth){1'b1}}};
			end else begin
				VGA_R <= '0;
				VGA_G <= '0;
				VGA_B <= '0;
			end
		end
	end

	// Coordinates from the FSM keep the read inside the buffer
	rdRange: assert property (
		@(posedge CLOCK_25) disable iff (!RESET_N)
		activeDly[0] |-> (rdAddr < fbAddrWidth'(fbDepth))
	) else $error("read address beyond buffer");

endmodule

`default_nettype wire

/* rtl/vgaFrameDriver.sv */
`default_nettype none

// VGA frame buffer driver top level
// Counter value to pins is four cycles
module vgaFrameDriver
	import videoTimingPkg::*;
	import frameBufferPkg::*;
(
	input  wire                     CLOCK_25,
	input  wire                     RESET_N,
	input  wire [coordWidth-1:0]    X,
	input  wire [coordWidth-1:0]    Y,
	input  wire [pixelWidth-1:0]    RGB,
	input  wire                     WR,
	output logic                    VGA_HSYNC,
	output logic                    VGA_VSYNC,
	output logic                    VGA_BLANK,
	output logic [dacWidth-1:0]     VGA_R,
	output logic [dacWidth-1:0]     VGA_G,
	output logic [dacWidth-1:0]     VGA_B
);

	logic [countWidth-1:0]  hCount;
	logic [countWidth-1:0]  vCount;
	logic                   lineEnd;
	logic [fbAddrWidth-1:0] rdAddr;
	logic [pixelWidth-1:0]  rdData;

	scanIf scan ();  // Timing to pixel path

	scanCounter i_scanCounter (
		.CLOCK_25 (CLOCK_25),
		.RESET_N  (RESET_N),
		.hCount   (hCount),
		.vCount   (vCount),
		.lineEnd  (lineEnd)
	);

	scanTimingFsm i_scanTimingFsm (
		.CLOCK_25 (CLOCK_25),
		.RESET_N  (RESET_N),
		.hCount   (hCount),
		.vCount   (vCount),
		.lineEnd  (lineEnd),
		.scan     (scan.source)
	);

	frameBuffer i_frameBuffer (
		.CLOCK_25 (CLOCK_25),
		.RESET_N  (RESET_N),
		.X        (X),
		.Y        (Y),
		.RGB      (RGB),
		.WR       (WR),
		.rdAddr   (rdAddr),
		.rdData   (rdData)
	);

	pixelOutput i_pixelOutput (
		.CLOCK_25  (CLOCK_25),
		.RESET_N   (RESET_N),
		.scan      (scan.sink),
		.rdAddr    (rdAddr),
		.rdData    (rdData),
		.VGA_HSYNC (VGA_HSYNC),
		.VGA_VSYNC (VGA_VSYNC),
		.VGA_BLANK (VGA_BLANK),
		.VGA_R     (VGA_R),
		.VGA_G     (VGA_G),
		.VGA_B     (VGA_B)
	);

endmodule

`default_nettype wire

/* bench/vgaFrameDriverTb.sv */
`default_nettype none

module vgaFrameDriverTb;
	timeunit 1ns;
	timeprecision 1ps;

	// Expected VGA timing, in pixel clocks and lines
	localparam int lineCycles  = 800;
	localparam int hSyncCycles = 96;
	localparam int visColStart = 140;
	localparam int visCols     = 640;
	localparam int frameLines  = 528;
	localparam int vSyncRows   = 2;
	localparam int visRowStart = 31;
	localparam int visRows     = 480;
	localparam int frameLen    = lineCycles * frameLines; // 422400 cycles

	// Buffer geometry
	localparam int fbCols  = 160;
	localparam int fbRows  = 120;
	localparam int fbWords = fbCols * fbRows;

	localparam int randSeed      = 97817;
	localparam int timeoutCycles = 3 * frameLen + fbWords + 1000;

	// Directed writes, X, Y, colour and whether the write lands
	localparam int numEntries = 9;
	localparam logic [7:0] tabX [numEntries] = '{
		8'd0, 8'd159, 8'd40, 8'd200, 8'd127, 8'd255, 8'd160, 8'd0, 8'd80};
	localparam logic [7:0] tabY [numEntries] = '{
		8'd0, 8'd119, 8'd1, 8'd0, 8'd51, 8'd255, 8'd0, 8'd120, 8'd60};
	localparam logic [11:0] tabRgb [numEntries] = '{
		12'hFFF, 12'h000, 12'hABC, 12'h123, 12'h3C5, 12'h789, 12'h456, 12'hE0F, 12'h5A5};
	// 200,0 hits 40,1 and 255,255 hits 127,51 if aliased, 160,0 hits 0,1
	localparam logic tabIn [numEntries] = '{
		1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};

	logic        CLOCK_25;
	logic        RESET_N;
	logic [7:0]  X;
	logic [7:0]  Y;
	logic [11:0] RGB;
	logic        WR;
	logic        VGA_HSYNC;
	logic        VGA_VSYNC;
	logic        VGA_BLANK;
	logic [9:0]  VGA_R;
	logic [9:0]  VGA_G;
	logic [9:0]  VGA_B;

	logic [11:0] model [fbWords]; // Expected buffer contents
	logic [11:0] rgbVal;
	int          cycleCount = 0;
	int          frameCycle;
	logic        prevH;      // Pin values one cycle back
	logic        prevV;
	logic        prevB;
	int          lineCycle;  // Cycles since HSYNC fell
	int          hFalls;
	int          hLowLen;
	int          vLowLen;
	int          runLen;     // Position inside BLANK high run
	int          runCount;   // Completed visible lines

	vgaFrameDriver i_vgaFrameDriver (
		.CLOCK_25  (CLOCK_25),
		.RESET_N   (RESET_N),
		.X         (X),
		.Y         (Y),
		.RGB       (RGB),
		.WR        (WR),
		.VGA_HSYNC (VGA_HSYNC),
		.VGA_VSYNC (VGA_VSYNC),
		.VGA_BLANK (VGA_BLANK),
		.VGA_R     (VGA_R),
		.VGA_G     (VGA_G),
		.VGA_B     (VGA_B)
	);

	always #5 CLOCK_25 = ~CLOCK_25; // 10 ns period

	always @(posedge CLOCK_25) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Run timed out after %0d cycles before the frame check ended", cycleCount);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input int expected, input int actual, input string what);
		if (expected != actual) begin
			$display("[FAIL] %0t ns %s expected %0h got %0h", $time, what, expected, actual);
			$display("Simulation failed");
			$fatal(1, "mismatch");
		end
	endtask

	// Row major word address
	function automatic logic [14:0] modelIndex(input int row, input int col);
		return 15'(row * fbCols + col);
	endfunction

	// One pin sample of the checked frame
	task automatic checkCycle(input int c);
		logic [11:0] word;
		if (prevH && !VGA_HSYNC) begin
			if (hFalls > 0)
				checkValue(lineCycles, lineCycle + 1, "HSYNC period"); // Includes this cycle
			hFalls++;
			lineCycle = 0;
			hLowLen   = 0;
		end else begin
			lineCycle++;
		end
		if (!VGA_HSYNC)
			hLowLen++;
		if (!prevH && VGA_HSYNC)
			checkValue(hSyncCycles, hLowLen, "HSYNC low width");

		if (prevV && !VGA_VSYNC) begin
			if (c > 0)
				checkValue(frameLen, c, "VSYNC period"); // No early second pulse
			vLowLen = 0;
		end
		if (!VGA_VSYNC)
			vLowLen++;
		if (!prevV && VGA_VSYNC)
			checkValue(vSyncRows * lineCycles, vLowLen, "VSYNC low width");
		if (c == frameLen)
			checkValue(1, int'(prevV && !VGA_VSYNC), "VSYNC fall after one frame");

		if (!prevB && VGA_BLANK) begin
			checkValue(visColStart, lineCycle, "BLANK rise within line");
			checkValue(visRowStart + runCount, hFalls - 1, "BLANK line within frame");
			runLen = 0;
		end
		if (prevB && !VGA_BLANK) begin
			checkValue(visCols, runLen, "BLANK high run length");
			runCount++;
		end
		if (VGA_BLANK) begin
			checkValue(1, int'(VGA_HSYNC && VGA_VSYNC), "BLANK high during sync");
			checkValue(1, int'(runLen < visCols && runCount < visRows), "BLANK outside visible area");
			word = model[modelIndex(runCount / 4, runLen / 4)]; // 4 x 4 block
			checkValue(int'({word[3:0], 6'b111111}), int'(VGA_R), "red channel");
			checkValue(int'({word[7:4], 6'b111111}), int'(VGA_G), "green channel");
			checkValue(int'({word[11:8], 6'b111111}), int'(VGA_B), "blue channel");
			runLen++;
		end else begin
			checkValue(0, int'(VGA_R), "red while blanked");
			checkValue(0, int'(VGA_G), "green while blanked");
			checkValue(0, int'(VGA_B), "blue while blanked");
		end
	endtask

	initial begin
		CLOCK_25 = 1'b0;
		RESET_N  = 1'b0;
		X        = '0;
		Y        = '0;
		RGB      = '0;
		WR       = 1'b0;
		void'($urandom(randSeed));

		// Idle pins throughout reset
		repeat (4) begin
			@(negedge CLOCK_25);
			checkValue(1, int'(VGA_HSYNC), "HSYNC in reset");
			checkValue(1, int'(VGA_VSYNC), "VSYNC in reset");
			checkValue(0, int'(VGA_BLANK), "BLANK in reset");
			checkValue(0, int'({VGA_R, VGA_G, VGA_B}), "colours in reset");
		end
		@(posedge CLOCK_25);
		RESET_N <= 1'b1;

		// Fill whole buffer within the first frame
		for (int row = 0; row < fbRows; row++) begin
			for (int col = 0; col < fbCols; col++) begin
				@(posedge CLOCK_25);
				rgbVal = 12'($urandom());
				X   <= 8'(col);
				Y   <= 8'(row);
				RGB <= rgbVal;
				WR  <= 1'b1;
				model[modelIndex(row, col)] = rgbVal;
			end
		end

		for (int i = 0; i < numEntries; i++) begin
			@(posedge CLOCK_25);
			X   <= tabX[4'(i)];
			Y   <= tabY[4'(i)];
			RGB <= tabRgb[4'(i)];
			if (tabIn[4'(i)])
				model[modelIndex(int'(tabY[4'(i)]), int'(tabX[4'(i)]))] = tabRgb[4'(i)];
		end
		@(posedge CLOCK_25);
		WR <= 1'b0;

		// Align to the next frame start
		@(negedge CLOCK_25);
		prevV = VGA_VSYNC;
		@(negedge CLOCK_25);
		while (!(prevV && !VGA_VSYNC)) begin
			prevV = VGA_VSYNC;
			@(negedge CLOCK_25);
		end

		prevH     = 1'b1; // Front porch before the frame start
		prevV     = 1'b1;
		prevB     = 1'b0;
		lineCycle = 0;
		hFalls    = 0;
		hLowLen   = 0;
		vLowLen   = 0;
		runLen    = 0;
		runCount  = 0;
		// Through the first cycle of the following frame
		for (frameCycle = 0; frameCycle <= frameLen; frameCycle++) begin
			if (frameCycle > 0)
				@(negedge CLOCK_25);
			checkCycle(frameCycle);
			prevH = VGA_HSYNC;
			prevV = VGA_VSYNC;
			prevB = VGA_BLANK;
		end
		checkValue(visRows, runCount, "visible lines per frame");
		checkValue(frameLines + 1, hFalls, "HSYNC pulses in checked span");

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
rtl/videoTimingPkg.sv
rtl/frameBufferPkg.sv
rtl/scanIf.sv
rtl/scanCounter.sv
rtl/scanTimingFsm.sv
rtl/frameBuffer.sv
rtl/pixelOutput.sv
rtl/vgaFrameDriver.sv
bench/vgaFrameDriverTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = vgaFrameDriverTb
FILELIST = compile.f
OBJDIR   = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
